// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := tb_rp_analog_top
FILELIST  := rp_analog.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) verif/tb_model.svh

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -qF '** PASS **' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: rp_analog.f
+incdir+verif
source/rp_analog_pkg.sv
source/sys_bus_decoder.sv
source/analog_regs.sv
source/adc_frontend.sv
source/dac_backend.sv
source/rp_analog_top.sv
verif/tb_rp_analog_top.sv

// File: source/adc_frontend.sv
//////////////////////////////////////////////////
// adc front end
// pin register, neg-slope to two's complement
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module adc_frontend
  import rp_analog_pkg::*;
(
  input  wire logic             adc_clk,
  input  wire logic             reset_i,
  input  wire logic [RAW_W-1:0] adc_dat_a_i,   // ch a pins
  input  wire logic [RAW_W-1:0] adc_dat_b_i,   // ch b pins
  output chan_pair_t            sample_o       // signed, one cycle after pins
);

  logic [DAT_W-1:0] raw_a;
  logic [DAT_W-1:0] raw_b;
  chan_pair_t       sample_q;

  // converter data sits on the upper 14 pins
  assign raw_a = adc_dat_a_i[RAW_W-1:RAW_W-DAT_W];
  assign raw_b = adc_dat_b_i[RAW_W-1:RAW_W-DAT_W];

  // loads every cycle, conversion ahead of the flops
  // so reset gives a true zero sample
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
      sample_q <= '0;
    else
    begin
      sample_q.a <= neg_slope(raw_a);
      sample_q.b <= neg_slope(raw_b);
    end
  end

  assign sample_o = sample_q;

endmodule

`default_nettype wire

// File: source/analog_regs.sv
//////////////////////////////////////////////////
// region 0 register bank
// id word, dac offsets, adc snapshot
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module analog_regs
  import rp_analog_pkg::*;
(
  input  wire logic adc_clk,
  input  wire logic reset_i,
  input  sys_req_t  req_i,          // strobes already gated to region 0
  output sys_rsp_t  rsp_o,          // combinational, registered in decoder
  input  chan_pair_t adc_sample_i,  // live adc samples
  output chan_pair_t offset_o       // to dac summation
);

  logic [7:0] reg_ofs;      // offset inside region
  logic       strobe;
  logic       ofs_hit;      // known register
  chan_pair_t ofs_q;

  // low two byte lanes cover the 14-bit offset
  function automatic logic [DAT_W-1:0] lane_write(
    input logic [DAT_W-1:0] old_val,
    input logic [BUS_W-1:0] wdata,
    input logic [3:0]       sel
  );
    logic [DAT_W-1:0] nxt;
    nxt = old_val;
    if (sel[0])
      nxt[7:0] = wdata[7:0];
    if (sel[1])
      nxt[DAT_W-1:8] = wdata[DAT_W-1:8];
    return nxt;
  endfunction

  assign reg_ofs = req_i.addr[7:0];
  assign strobe  = req_i.wen | req_i.ren;
  assign ofs_hit = (reg_ofs == REG_ID) || (reg_ofs == REG_OFS_A) ||
                   (reg_ofs == REG_OFS_B) || (reg_ofs == REG_SNAP);

  //////////////////////////////////////////////////
  // offset registers
  //////////////////////////////////////////////////
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
      ofs_q <= '0;
    else if (req_i.wen)
    begin
      if (reg_ofs == REG_OFS_A)
        ofs_q.a <= lane_write(ofs_q.a, req_i.wdata, req_i.sel);
      if (reg_ofs == REG_OFS_B)
        ofs_q.b <= lane_write(ofs_q.b, req_i.wdata, req_i.sel);
    end
  end

  assign offset_o = ofs_q;

  //////////////////////////////////////////////////
  // read mux
  //////////////////////////////////////////////////
  // signed members, so the size casts sign-extend
  // snapshot is whatever the front end holds at the read strobe
  always_comb
  begin
    rsp_o.ack   = strobe;
    rsp_o.err   = strobe & ~ofs_hit;    // unknown offset
    rsp_o.rdata = '0;
    if (req_i.ren)
    begin
      case (reg_ofs)
        REG_ID:    rsp_o.rdata = ID_VALUE;
        REG_OFS_A: rsp_o.rdata = BUS_W'(ofs_q.a);
        REG_OFS_B: rsp_o.rdata = BUS_W'(ofs_q.b);
        REG_SNAP:  rsp_o.rdata = {16'(adc_sample_i.b), 16'(adc_sample_i.a)};
        default:   rsp_o.rdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/dac_backend.sv
//////////////////////////////////////////////////
// dac back end
// offset add, saturation, neg-slope code register
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dac_backend
  import rp_analog_pkg::*;
(
  input  wire logic adc_clk,
  input  wire logic reset_i,
  input  chan_pair_t sample_i,     // adc samples, two's complement
  input  chan_pair_t offset_i,     // per channel offset
  output chan_pair_t dac_dat_o     // unsigned neg-slope codes
);

  logic signed [SUM_W-1:0] sum_a;
  logic signed [SUM_W-1:0] sum_b;
  logic [DAT_W-1:0]        sat_a;
  logic [DAT_W-1:0]        sat_b;
  chan_pair_t              dac_q;

  // clamp 15-bit sum into 14 bits
  // top two bits differ -> out of range, pick the rail by sign
  function automatic logic [DAT_W-1:0] saturate(input logic [SUM_W-1:0] s);
    logic ovf;
    ovf = s[SUM_W-1] ^ s[SUM_W-2];
    if (ovf)
      return {s[SUM_W-1], {(DAT_W-1){~s[SUM_W-1]}}};  // 8191 or -8192
    else
      return s[DAT_W-1:0];
  endfunction

  //////////////////////////////////////////////////
  // summation
  //////////////////////////////////////////////////
  // both operands signed, extended to SUM_W by context
  assign sum_a = sample_i.a + offset_i.a;
  assign sum_b = sample_i.b + offset_i.b;

  assign sat_a = saturate(sum_a);
  assign sat_b = saturate(sum_b);

  //////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      dac_q.a <= neg_slope('0);      // mid-scale code 0x1fff
      dac_q.b <= neg_slope('0);
    end
    else
    begin
      dac_q.a <= neg_slope(sat_a);
      dac_q.b <= neg_slope(sat_b);
    end
  end

  assign dac_dat_o = dac_q;    // channels leave as parallel words

endmodule

`default_nettype wire

// File: source/rp_analog_pkg.sv
//////////////////////////////////////////////////
// analog path package
// widths, bus map, register offsets and shared types
//////////////////////////////////////////////////

`default_nettype none

package rp_analog_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////
  localparam int DAT_W = 14;       // converter sample
  localparam int SUM_W = 15;       // sample + offset, one guard bit
  localparam int RAW_W = 16;       // adc pins, low 2 bits unused
  localparam int BUS_W = 32;       // sys bus addr / data

  // bus map, eight regions on addr[22:20]
  localparam int N_REGION   = 8;
  localparam int REGION_LSB = 20;
  localparam int REGION_MSB = 22;

  // region 0 register offsets, decoded on addr[7:0]
  localparam logic [7:0] REG_ID    = 8'h00;
  localparam logic [7:0] REG_OFS_A = 8'h04;
  localparam logic [7:0] REG_OFS_B = 8'h08;
  localparam logic [7:0] REG_SNAP  = 8'h0C;

  localparam logic [BUS_W-1:0] ID_VALUE = 32'h5250_0001;

  //////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////
  typedef struct packed {
    logic [BUS_W-1:0] addr;
    logic [BUS_W-1:0] wdata;
    logic [3:0]       sel;        // byte lanes
    logic             wen;        // one-cycle strobe
    logic             ren;        // one-cycle strobe
  } sys_req_t;

  typedef struct packed {
    logic [BUS_W-1:0] rdata;
    logic             ack;
    logic             err;
  } sys_rsp_t;

  // one word per channel
  typedef struct packed {
    logic signed [DAT_W-1:0] a;
    logic signed [DAT_W-1:0] b;
  } chan_pair_t;

  // negative-slope offset binary <-> two's complement, self-inverse
  function automatic logic [DAT_W-1:0] neg_slope(input logic [DAT_W-1:0] d);
    return {d[DAT_W-1], ~d[DAT_W-2:0]};
  endfunction

endpackage

`default_nettype wire

// File: source/rp_analog_top.sv
//////////////////////////////////////////////////
// analog top
// bus decoder, region 0 registers and adc -> dac path
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rp_analog_top
  import rp_analog_pkg::*;
(
  input  wire logic             adc_clk,
  input  wire logic             reset_i,
  input  wire logic [RAW_W-1:0] adc_dat_a_i,
  input  wire logic [RAW_W-1:0] adc_dat_b_i,
  input  sys_req_t              sys_req_i,
  output sys_rsp_t              sys_rsp_o,
  output chan_pair_t            dac_dat_o
);

  sys_req_t   region0_req;   // gated strobes
  sys_rsp_t   region0_rsp;   // same cycle as strobe
  chan_pair_t adc_sample;
  chan_pair_t dac_offset;

  //////////////////////////////////////////////////
  // register bus
  //////////////////////////////////////////////////
  sys_bus_decoder i_sys_bus_decoder (
    .adc_clk      (adc_clk),
    .reset_i      (reset_i),
    .req_i        (sys_req_i),
    .region_req_o (region0_req),
    .region_rsp_i (region0_rsp),
    .rsp_o        (sys_rsp_o)
  );

  analog_regs i_analog_regs (
    .adc_clk      (adc_clk),
    .reset_i      (reset_i),
    .req_i        (region0_req),
    .rsp_o        (region0_rsp),
    .adc_sample_i (adc_sample),
    .offset_o     (dac_offset)
  );

  //////////////////////////////////////////////////
  // data path, two registers pin to pin
  //////////////////////////////////////////////////
  adc_frontend i_adc_frontend (
    .adc_clk     (adc_clk),
    .reset_i     (reset_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .sample_o    (adc_sample)
  );

  dac_backend i_dac_backend (
    .adc_clk   (adc_clk),
    .reset_i   (reset_i),
    .sample_i  (adc_sample),
    .offset_i  (dac_offset),
    .dac_dat_o (dac_dat_o)
  );

endmodule

`default_nettype wire

// File: source/sys_bus_decoder.sv
//////////////////////////////////////////////////
// system bus decoder
// eight regions, strobe routing, registered response
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module sys_bus_decoder
  import rp_analog_pkg::*;
(
  input  wire logic adc_clk,
  input  wire logic reset_i,
  input  sys_req_t  req_i,          // from bus master
  output sys_req_t  region_req_o,   // region 0 only, others are empty
  input  sys_rsp_t  region_rsp_i,   // region 0 response, same cycle as strobe
  output sys_rsp_t  rsp_o           // one cycle after the strobe
);

  logic [REGION_MSB-REGION_LSB:0] region_idx;
  logic [N_REGION-1:0]            region_cs;    // one-hot region select
  logic                           strobe;

  logic [N_REGION-1:0] region_cs_q;
  logic                strobe_q;      // pending strobe
  sys_rsp_t            rsp0_q;        // region 0 response, held one cycle

  //////////////////////////////////////////////////
  // request side
  //////////////////////////////////////////////////
  assign region_idx = req_i.addr[REGION_MSB:REGION_LSB];
  assign region_cs  = N_REGION'(1) << region_idx;
  assign strobe     = req_i.wen | req_i.ren;

  // addr, data and sel go straight through
  // strobes only when region 0 is hit
  always_comb
  begin
    region_req_o     = req_i;
    region_req_o.wen = req_i.wen & region_cs[0];
    region_req_o.ren = req_i.ren & region_cs[0];
  end

  //////////////////////////////////////////////////
  // response register
  //////////////////////////////////////////////////
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
      strobe_q <= 1'b0;
    else
      strobe_q <= strobe;           // ack always the next cycle
  end

  // region index and region 0 answer of the strobe cycle
  always_ff @(posedge adc_clk)
  begin
    region_cs_q <= region_cs;
    rsp0_q      <= region_rsp_i;
  end

  // region 0 gives its own answer
  // regions 1..7 ack with zero data, no error
  always_comb
  begin
    rsp_o.ack   = strobe_q & (region_cs_q[0] ? rsp0_q.ack : |region_cs_q[N_REGION-1:1]);
    rsp_o.err   = strobe_q & region_cs_q[0] & rsp0_q.err;
    rsp_o.rdata = (strobe_q & region_cs_q[0]) ? rsp0_q.rdata : '0;
  end

endmodule

`default_nettype wire

// File: verif/tb_model.svh
//////////////////////////////////////////////////
// testbench reference model
// code conversion, clamp, lane writes, register reads
//////////////////////////////////////////////////

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// 14-bit two's complement word -> int
function automatic int sval14(input logic [13:0] x);
  return x[13] ? int'(x) - 16384 : int'(x);
endfunction

// neg-slope code -> value
// code 0 is positive full scale
function automatic int code_to_val(input logic [13:0] code);
  return 8191 - int'(code);
endfunction

function automatic logic [13:0] val_to_code(input int v);
  int c;
  c = 8191 - v;
  return c[13:0];
endfunction

function automatic int clamp14(input int s);
  if (s > 8191)
    return 8191;
  else if (s < -8192)
    return -8192;
  return s;
endfunction

// pin word + offset -> expected dac code
function automatic logic [13:0] dac_expected(input logic [15:0] pin, input logic [13:0] ofs);
  return val_to_code(clamp14(code_to_val(pin[15:2]) + sval14(ofs)));
endfunction

// sel[0] -> bits 7:0, sel[1] -> bits 13:8
function automatic logic [13:0] lane_update(input logic [13:0] old, input logic [31:0] wdata,
                                            input logic [3:0] sel);
  logic [13:0] mask;
  mask = {{6{sel[1]}}, {8{sel[0]}}};
  return (old & ~mask) | (wdata[13:0] & mask);
endfunction

// readback of id and offsets
function automatic logic [31:0] reg_expected(input logic [7:0] ofs, input logic [13:0] mir_a,
                                             input logic [13:0] mir_b);
  case (ofs)
    REG_ID:    return 32'h5250_0001;
    REG_OFS_A: return sval14(mir_a);
    REG_OFS_B: return sval14(mir_b);
    default:   return 32'd0;
  endcase
endfunction

function automatic logic [31:0] snap_expected(input logic [15:0] pa, input logic [15:0] pb);
  logic [31:0] wa;
  logic [31:0] wb;
  wa = code_to_val(pa[15:2]);
  wb = code_to_val(pb[15:2]);
  return {wb[15:0], wa[15:0]};    // b high, a low
endfunction

`endif

// File: verif/tb_rp_analog_top.sv
//////////////////////////////////////////////////
// testbench for the analog top
// bus, register and adc -> dac checks against a model
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_rp_analog_top
  import rp_analog_pkg::*;
();

  localparam int CLK_NS    = 10;
  localparam int N_RW      = 40;    // offset write / readback pairs
  localparam int N_ROUND   = 200;   // round-trip samples
  localparam int N_BLOCK   = 8;     // offset sets in sum test
  localparam int BLOCK_LEN = 25;
  // bus access takes 2 cycles, streams drain 2 cycles
  localparam int TEST_CYCLES = 4 + 17 * 2 + N_RW * 4 + 4 + N_ROUND + 2 +
                               N_BLOCK * (4 + BLOCK_LEN + 2) + 6;
  localparam int TIMEOUT_NS  = TEST_CYCLES * CLK_NS + 1000;

  logic             adc_clk;
  logic             reset_i;
  logic [RAW_W-1:0] adc_dat_a_i;
  logic [RAW_W-1:0] adc_dat_b_i;
  sys_req_t         sys_req_i;
  sys_rsp_t         sys_rsp_o;
  chan_pair_t       dac_dat_o;

  int          n_checks;
  int          n_errors;
  int          err_mark;        // errors before current test
  logic [13:0] mirror_a;        // offset register copies
  logic [13:0] mirror_b;
  logic [27:0] dac_exp_q[$];    // expected {a, b}, two deep

  `include "tb_model.svh"

  rp_analog_top i_rp_analog_top (
    .adc_clk     (adc_clk),
    .reset_i     (reset_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .sys_req_i   (sys_req_i),
    .sys_rsp_o   (sys_rsp_o),
    .dac_dat_o   (dac_dat_o)
  );

  initial
  begin
    adc_clk = 1'b0;
    forever #(CLK_NS / 2) adc_clk = ~adc_clk;
  end

  // watchdog
  initial
  begin
    #(TIMEOUT_NS);
    $display("timeout: run still going after %0d ns, a test is stuck", TIMEOUT_NS);
    $display("** FAIL **");
    $finish;
  end

  task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("error @ %0t ns: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic end_test(input int num, input string name);
    $display("test %0d %s done, %0d errors", num, name, n_errors - err_mark);
    err_mark = n_errors;
  endtask

  // one strobe, ack only on the following edge
  task automatic bus_access(input logic [31:0] addr, input logic wr, input logic [31:0] wdata,
                            input logic [3:0] sel, output logic [31:0] rdata, output logic err);
    sys_req_i.addr  = addr;
    sys_req_i.wdata = wdata;
    sys_req_i.sel   = sel;
    sys_req_i.wen   = wr;
    sys_req_i.ren   = ~wr;
    check_val("ack before strobe edge", 32'(sys_rsp_o.ack), 32'd0);
    @(posedge adc_clk);
    #1;
    sys_req_i.wen = 1'b0;
    sys_req_i.ren = 1'b0;
    check_val("ack one cycle after strobe", 32'(sys_rsp_o.ack), 32'd1);
    rdata = sys_rsp_o.rdata;
    err   = sys_rsp_o.err;
    @(posedge adc_clk);
    #1;
    check_val("ack dropped", 32'(sys_rsp_o.ack), 32'd0);
  endtask

  task automatic write_offsets(input logic [13:0] ofs_a, input logic [13:0] ofs_b);
    logic [31:0] rd;
    logic        er;
    bus_access(32'(REG_OFS_A), 1'b1, 32'(ofs_a), 4'hF, rd, er);
    bus_access(32'(REG_OFS_B), 1'b1, 32'(ofs_b), 4'hF, rd, er);
    mirror_a = ofs_a;
    mirror_b = ofs_b;
  endtask

  // compare oldest word once two are in flight, or while draining
  task automatic stream_step(input logic push, input logic [15:0] pa, input logic [15:0] pb);
    if (dac_exp_q.size() == 2 || (!push && dac_exp_q.size() != 0))
      check_val("dac words {a,b}", 32'({dac_dat_o.a, dac_dat_o.b}), 32'(dac_exp_q.pop_front()));
    if (push)
    begin
      adc_dat_a_i = pa;
      adc_dat_b_i = pb;
      dac_exp_q.push_back({dac_expected(pa, mirror_a), dac_expected(pb, mirror_b)});
    end
    @(posedge adc_clk);
    #1;
  endtask

  // a quarter at each rail
  function automatic logic [15:0] pick_pin();
    logic [15:0] p;
    p = 16'($urandom);
    case ($urandom % 4)
      0: p[15:2] = '0;        // positive full scale
      1: p[15:2] = '1;        // negative full scale
      default: ;
    endcase
    return p;
  endfunction

  initial
  begin
    logic [31:0] rd;
    logic [31:0] addr;
    logic [31:0] wd;
    logic [3:0]  sel;
    logic [15:0] pa;
    logic [15:0] pb;
    logic        er;
    int          seed_ret;
    seed_ret    = $urandom(32'h74ae);
    n_checks    = 0;
    n_errors    = 0;
    err_mark    = 0;
    mirror_a    = '0;
    mirror_b    = '0;
    reset_i     = 1'b1;
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    sys_req_i   = '0;
    repeat (2) @(posedge adc_clk);
    #1;
    reset_i = 1'b0;

    //////////////////////////////////////////////////
    // 1: reset state
    check_val("dac a at reset", 32'(dac_dat_o.a), 32'h1FFF);
    check_val("dac b at reset", 32'(dac_dat_o.b), 32'h1FFF);
    check_val("ack at reset", 32'(sys_rsp_o.ack), 32'd0);
    bus_access(32'(REG_OFS_A), 1'b0, 32'd0, 4'hF, rd, er);
    check_val("offset a after reset", rd, 32'd0);
    end_test(1, "reset");

    // 2: id, bad offsets, empty regions
    bus_access(32'(REG_ID), 1'b0, 32'd0, 4'hF, rd, er);
    check_val("id word", rd, reg_expected(REG_ID, mirror_a, mirror_b));
    check_val("id err", 32'(er), 32'd0);
    bus_access(32'h10, 1'b0, 32'd0, 4'hF, rd, er);
    check_val("undefined offset err", 32'(er), 32'd1);
    check_val("undefined offset data", rd, reg_expected(8'h10, mirror_a, mirror_b));
    bus_access(32'hFC, 1'b0, 32'd0, 4'hF, rd, er);
    check_val("undefined offset err", 32'(er), 32'd1);
    for (int r = 1; r < N_REGION; r++)
    begin
      addr = (32'(r) << REGION_LSB) | ($urandom & 32'h000F_FFFC);
      bus_access(addr, 1'b0, 32'd0, 4'hF, rd, er);
      check_val("empty region read data", rd, 32'd0);
      check_val("empty region read err", 32'(er), 32'd0);
      bus_access(addr, 1'b1, $urandom, 4'hF, rd, er);
      check_val("empty region write data", rd, 32'd0);
      check_val("empty region write err", 32'(er), 32'd0);
    end
    end_test(2, "bus map");

    // 3: offset byte-lane writes, read back
    for (int i = 0; i < N_RW; i++)
    begin
      addr = ($urandom % 2) ? 32'(REG_OFS_B) : 32'(REG_OFS_A);
      wd   = $urandom;
      sel  = 4'($urandom);
      bus_access(addr, 1'b1, wd, sel, rd, er);
      if (addr[7:0] == REG_OFS_A)
        mirror_a = lane_update(mirror_a, wd, sel);
      else
        mirror_b = lane_update(mirror_b, wd, sel);
      bus_access(addr, 1'b0, 32'd0, 4'hF, rd, er);
      check_val("offset readback", rd, reg_expected(addr[7:0], mirror_a, mirror_b));
    end
    end_test(3, "offset readback");

    // 4: zero offsets
    // both conversions back to back
    write_offsets('0, '0);
    for (int i = 0; i < N_ROUND; i++)
      stream_step(1'b1, 16'($urandom), 16'($urandom));
    repeat (2) stream_step(1'b0, '0, '0);
    end_test(4, "round trip");

    // 5: offsets and rails
    // first two blocks pin the offsets to full scale
    for (int blk = 0; blk < N_BLOCK; blk++)
    begin
      if (blk == 0)
        write_offsets(14'h1FFF, 14'h2000);
      else if (blk == 1)
        write_offsets(14'h2000, 14'h1FFF);
      else
        write_offsets(14'($urandom), 14'($urandom));
      for (int i = 0; i < BLOCK_LEN; i++)
        stream_step(1'b1, pick_pin(), pick_pin());
      repeat (2) stream_step(1'b0, '0, '0);
    end
    end_test(5, "offset sum");

    // 6: snapshot with steady pins
    pa          = 16'($urandom);
    pb          = 16'($urandom);
    adc_dat_a_i = pa;
    adc_dat_b_i = pb;
    repeat (2) @(posedge adc_clk);
    #1;
    bus_access(32'(REG_SNAP), 1'b0, 32'd0, 4'hF, rd, er);
    check_val("snapshot", rd, snap_expected(pa, pb));
    check_val("snapshot err", 32'(er), 32'd0);
    end_test(6, "snapshot");

    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire
